//--- bench/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_core_tb;

    logic                   clk;
    logic                   rst_n;
    logic                   run;
    logic                   imem_we;
    logic [`RV_IMEM_AW-1:0] imem_addr;
    logic [31:0]            imem_data;
    logic                   retire_valid;
    logic [31:0]            retire_pc;
    logic [4:0]             retire_rd;
    logic [31:0]            retire_data;
    logic                   halted;
    logic [31:0]            rega0;

    logic [31:0] prog [`RV_IMEM_DEPTH];
    int          plen;
    logic [15:0] lfsr;
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    logic [31:0] model_a0;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;

    rv_core_top u_rv_core_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .halted       (halted),
        .rega0        (rega0)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////
    // Random numbers and encoders
    ////////////////////////////////////////

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + (rand_bits(8) % (hi - lo + 1));
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    // ADDI only
    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [4:0] rd);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_b(input int off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input int off, input logic [4:0] rd);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], rd, 7'b1101111};
    endfunction

    ////////////////////////////////////////
    // Program builder
    ////////////////////////////////////////

    function automatic void emit(input logic [31:0] w);
        prog[plen] = w;
        plen++;
    endfunction

    // One of ADD SUB AND OR XOR SLT ADDI on x0 to x10
    function automatic logic [31:0] rand_alu();
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        rd  = 5'(rand_range(0, 10));
        rs1 = 5'(rand_range(0, 10));
        rs2 = 5'(rand_range(0, 10));
        case (rand_range(0, 6))
            0:       return enc_r(7'h00, rs2, rs1, 3'b000, rd);
            1:       return enc_r(7'h20, rs2, rs1, 3'b000, rd);
            2:       return enc_r(7'h00, rs2, rs1, 3'b111, rd);
            3:       return enc_r(7'h00, rs2, rs1, 3'b110, rd);
            4:       return enc_r(7'h00, rs2, rs1, 3'b100, rd);
            5:       return enc_r(7'h00, rs2, rs1, 3'b010, rd);
            default: return enc_i(12'(rand_bits(12)), rs1, rd);
        endcase
    endfunction

    // Every program first gives x1 to x10 a defined value
    function automatic void start_prog();
        plen = 0;
        for (int i = 1; i <= 10; i++) begin
            emit(enc_i(12'(rand_bits(12)), 5'd0, 5'(i)));
        end
    endfunction

    function automatic void add_straight(input int n);
        repeat (n) emit(rand_alu());
    endfunction

    // Forward BEQ or BNE skipping one to three words
    function automatic void add_fwd_branch();
        int         k;
        logic [4:0] rs1;
        logic [4:0] rs2;
        k   = rand_range(1, 3);
        rs1 = 5'(rand_range(0, 10));
        rs2 = rand_bits(1) ? rs1 : 5'(rand_range(0, 10));
        emit(enc_b((k + 1) * 4, rs2, rs1, rand_bits(1) ? 3'b001 : 3'b000));
        repeat (k) emit(rand_alu());
    endfunction

    // x11 counts down and a BNE closes the loop
    function automatic void add_loop();
        int body;
        body = rand_range(1, 3);
        emit(enc_i(12'(rand_range(1, 6)), 5'd0, 5'd11));
        repeat (body) emit(rand_alu());
        emit(enc_i(12'hfff, 5'd11, 5'd11));
        emit(enc_b(-(body + 1) * 4, 5'd0, 5'd11, 3'b001));
    endfunction

    function automatic void add_jal();
        int k;
        k = rand_range(1, 2);
        emit(enc_j((k + 1) * 4, 5'(rand_range(1, 10))));
        repeat (k) emit(rand_alu());
    endfunction

    ////////////////////////////////////////
    // Reference interpreter
    ////////////////////////////////////////

    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] next;
        logic [31:0] joff;
        logic        wr;
        logic        done;
        int          steps;
        exp_pc.delete();
        exp_rd.delete();
        exp_data.delete();
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 2000) begin
            instr = prog[pc[`RV_IMEM_AW+1:2]];
            a     = regs[instr[19:15]];
            b     = regs[instr[24:20]];
            wr    = 1'b0;
            res   = '0;
            next  = pc + 4;
            steps++;
            case (instr[6:0])
                7'b0110011: begin
                    wr = 1'b1;
                    case ({instr[30], instr[14:12]})
                        4'b0000: res = a + b;
                        4'b1000: res = a - b;
                        4'b0111: res = a & b;
                        4'b0110: res = a | b;
                        4'b0100: res = a ^ b;
                        4'b0010: res = {31'b0, $signed(a) < $signed(b)};
                        default: wr = 1'b0;
                    endcase
                end
                7'b0010011: begin
                    wr  = 1'b1;
                    res = a + {{20{instr[31]}}, instr[31:20]};
                end
                // funct3 bit 0 set means BNE
                7'b1100011: begin
                    if ((a == b) != instr[12]) begin
                        next = pc + {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                     instr[11:8], 1'b0};
                    end
                end
                7'b1101111: begin
                    joff = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
                    wr   = 1'b1;
                    res  = pc + 4;
                    next = pc + joff;
                    done = (joff == 0);
                end
                default: ;
            endcase
            if (!done) begin
                if (wr && instr[11:7] != 5'd0) begin
                    regs[instr[11:7]] = res;
                end
                exp_pc.push_back(pc);
                exp_rd.push_back((wr && instr[11:7] != 5'd0) ? instr[11:7] : 5'd0);
                exp_data.push_back((wr && instr[11:7] != 5'd0) ? res : 32'd0);
            end
            pc = next;
        end
        model_a0 = regs[10];
    endtask

    ////////////////////////////////////////
    // DUT control and checks
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        run   = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // Unused words hold an ADDI to x0 with the address as immediate
    task automatic load_program();
        for (int a = 0; a < `RV_IMEM_DEPTH; a++) begin
            @(negedge clk);
            imem_we   = 1'b1;
            imem_addr = a[`RV_IMEM_AW-1:0];
            imem_data = (a < plen) ? prog[a] : {a[11:0], 20'h00013};
        end
        @(negedge clk);
        imem_we = 1'b0;
    endtask

    task automatic compare_retire();
        checks++;
        assert (exp_pc.size() > 0) else begin
            $display("retire at pc %h after the model already halted", retire_pc);
            errors++;
        end
        if (exp_pc.size() > 0) begin
            check_value("retire_pc", retire_pc, exp_pc.pop_front());
            check_value("retire_rd", {27'b0, retire_rd}, {27'b0, exp_rd.pop_front()});
            check_value("retire_data", retire_data, exp_data.pop_front());
        end
    endtask

    task automatic run_program();
        int cycles;
        run_model();
        load_program();
        run    = 1'b1;
        cycles = 0;
        while (!halted && cycles < 2000) begin
            @(negedge clk);
            cycles++;
            if (retire_valid) begin
                compare_retire();
            end
        end
        checks++;
        assert (halted) else begin
            $display("halted did not rise within 2000 cycles of run");
            errors++;
        end
        // Nothing may retire once halted
        repeat (5) begin
            @(negedge clk);
            checks++;
            assert (!retire_valid) else begin
                $display("retire at pc %h after halt", retire_pc);
                errors++;
            end
        end
        checks++;
        assert (exp_pc.size() == 0) else begin
            $display("%0d expected instructions never retired", exp_pc.size());
            errors++;
        end
        check_value("rega0", rega0, model_a0);
        run = 1'b0;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        int e0;
        rst_n        = 1'b0;
        run          = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_data    = '0;
        lfsr         = 16'd40516;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;

        e0 = errors;
        apply_reset();
        check_value("retire_valid", {31'b0, retire_valid}, 32'd0);
        check_value("halted", {31'b0, halted}, 32'd0);
        finish_test("idle after reset", e0);

        e0 = errors;
        apply_reset();
        start_prog();
        add_straight(30);
        emit(enc_j(0, 5'd0));
        run_program();
        finish_test("straight-line ALU", e0);

        e0 = errors;
        apply_reset();
        start_prog();
        repeat (8) add_fwd_branch();
        emit(enc_j(0, 5'd0));
        run_program();
        finish_test("forward branches", e0);

        e0 = errors;
        apply_reset();
        start_prog();
        add_loop();
        add_straight(2);
        emit(enc_j(0, 5'd0));
        run_program();
        finish_test("counted loop", e0);

        e0 = errors;
        apply_reset();
        start_prog();
        add_jal();
        add_straight(2);
        add_jal();
        emit(enc_j(0, 5'd0));
        run_program();
        finish_test("JAL and halt", e0);

        // Mixed programs with a reset before each
        for (int p = 0; p < 3; p++) begin
            e0 = errors;
            apply_reset();
            start_prog();
            add_straight(rand_range(2, 6));
            add_fwd_branch();
            add_fwd_branch();
            add_loop();
            add_jal();
            add_straight(2);
            emit(enc_j(0, 5'd0));
            run_program();
            finish_test("mixed program", e0);
        end

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module execute_stage (
    input  logic                clk,
    input  logic                rst_n,

    // From the stage buffer
    input  logic                in_valid,
    input  rv_pkg::fetch_word_t in_word,

    // Register file read
    output logic [4:0]          rs1_addr,
    output logic [4:0]          rs2_addr,
    input  logic [`RV_XLEN-1:0] rs1_data,
    input  logic [`RV_XLEN-1:0] rs2_data,

    // Register file write
    output logic                wr_en,
    output logic [4:0]          wr_addr,
    output logic [`RV_XLEN-1:0] wr_data,

    // Fetch correction
    output logic                redirect,
    output logic [`RV_XLEN-1:0] redirect_pc,

    // Retire trace
    output logic                retire_valid,
    output logic [`RV_XLEN-1:0] retire_pc,
    output logic [4:0]          retire_rd,
    output logic [`RV_XLEN-1:0] retire_data,

    output logic                halted
);

    import rv_pkg::*;

    logic [31:0]         instr;
    logic [`RV_XLEN-1:0] pc;
    opcode_t             opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [4:0]          rd;

    alu_op_t             alu_op;
    logic                is_alu;
    logic                alu_use_imm;
    logic                is_branch;
    logic                is_jal;
    logic                is_halt;
    logic                active;

    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic                branch_taken;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] target;
    logic [`RV_XLEN-1:0] actual_next;
    logic [`RV_XLEN-1:0] predicted_next;
    logic                writes_rd;

    assign instr  = in_word.instr;
    assign pc     = in_word.pc;
    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    // Anything unrecognised falls through as a no-op
    always_comb begin
        alu_op      = ALU_ADD;
        is_alu      = 1'b0;
        alu_use_imm = 1'b0;
        is_branch   = 1'b0;
        is_jal      = 1'b0;
        case (opcode)
            OPC_OP: begin
                is_alu = 1'b1;
                case (funct3)
                    3'b000:  alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: is_alu = 1'b0;
                endcase
                // Only SUB may carry a nonzero funct7
                if (funct7 != 7'b0000000 && !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
                    is_alu = 1'b0;
                end
            end
            OPC_OP_IMM: begin
                is_alu      = (funct3 == 3'b000);
                alu_use_imm = 1'b1;
            end
            OPC_BRANCH: is_branch = (funct3 == 3'b000) || (funct3 == 3'b001);
            OPC_JAL:    is_jal = 1'b1;
            default:    ;
        endcase
    end

    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    assign alu_b = alu_use_imm ? get_imm_i(instr) : rs2_data;

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_result = rs1_data - alu_b;
            ALU_AND: alu_result = rs1_data & alu_b;
            ALU_OR:  alu_result = rs1_data | alu_b;
            ALU_XOR: alu_result = rs1_data ^ alu_b;
            ALU_SLT: alu_result = {{(`RV_XLEN-1){1'b0}}, $signed(rs1_data) < $signed(alu_b)};
            default: alu_result = rs1_data + alu_b;
        endcase
    end

    ////////////////////////////////////////
    // Branch resolution
    ////////////////////////////////////////

    // funct3 bit 0 separates BNE from BEQ
    assign branch_taken = is_branch && (funct3[0] ? (rs1_data != rs2_data)
                                                  : (rs1_data == rs2_data));

    assign pc_plus4       = pc + `RV_XLEN'd4;
    assign target         = pc + (is_jal ? get_imm_j(instr) : get_imm_b(instr));
    assign actual_next    = (branch_taken || is_jal) ? target : pc_plus4;
    assign predicted_next = in_word.predicted_taken ? target : pc_plus4;

    // Jump to itself stops the core
    assign is_halt = is_jal && (get_imm_j(instr) == '0);
    assign active  = in_valid && !halted;

    assign redirect    = active && (actual_next != predicted_next);
    assign redirect_pc = actual_next;

    ////////////////////////////////////////
    // Write-back and retire
    ////////////////////////////////////////

    assign writes_rd = (is_alu || is_jal) && !is_halt;

    assign wr_en   = active && writes_rd;
    assign wr_addr = rd;
    assign wr_data = is_jal ? pc_plus4 : alu_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            halted       <= 1'b0;
        end else begin
            retire_valid <= active && !is_halt;
            if (active && is_halt) begin
                halted <= 1'b1;
            end
        end
    end

    // Non-writing and x0 targets report rd 0 with zero data
    always_ff @(posedge clk) begin
        if (active) begin
            retire_pc   <= pc;
            retire_rd   <= (writes_rd && rd != 5'd0) ? rd : 5'd0;
            retire_data <= (writes_rd && rd != 5'd0) ? wr_data : '0;
        end
    end

endmodule

//--- design/fetch_stage.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module fetch_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   run,

    // Program load port
    input  logic                   imem_we,
    input  logic [`RV_IMEM_AW-1:0] imem_addr,
    input  logic [`RV_XLEN-1:0]    imem_data,

    // Correction from execute
    input  logic                   redirect,
    input  logic [`RV_XLEN-1:0]    redirect_pc,

    output logic                   fetch_valid,
    output rv_pkg::fetch_word_t    fetch_word
);

    import rv_pkg::*;

    logic [`RV_XLEN-1:0]    imem [`RV_IMEM_DEPTH];

    logic [`RV_XLEN-1:0]    pc;
    logic [`RV_XLEN-1:0]    pc_plus4;
    logic [`RV_XLEN-1:0]    pred_target;
    logic [`RV_XLEN-1:0]    next_pc;
    logic [`RV_IMEM_AW-1:0] word_addr;
    logic [31:0]            instr;
    opcode_t                opcode;
    logic                   is_jal;
    logic                   is_back_branch;
    logic                   predict_taken;

    ////////////////////////////////////////
    // Instruction memory
    ////////////////////////////////////////

    // Loading only while the core is stopped
    always_ff @(posedge clk) begin
        if (imem_we && !run) begin
            imem[imem_addr] <= imem_data;
        end
    end

    assign word_addr = pc[`RV_IMEM_AW+1:2];
    assign instr     = imem[word_addr];

    ////////////////////////////////////////
    // Static predictor
    ////////////////////////////////////////

    assign opcode = opcode_t'(instr[6:0]);

    // Backward branch has a negative B immediate, so bit 31 is set
    assign is_jal         = (opcode == OPC_JAL);
    assign is_back_branch = (opcode == OPC_BRANCH) && instr[31];
    assign predict_taken  = is_jal || is_back_branch;

    assign pc_plus4    = pc + `RV_XLEN'd4;
    assign pred_target = pc + (is_jal ? get_imm_j(instr) : get_imm_b(instr));
    assign next_pc     = predict_taken ? pred_target : pc_plus4;

    ////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (run) begin
            pc <= next_pc;
        end
    end

    // One word per cycle while running
    assign fetch_valid = run && !redirect;

    always_comb begin
        fetch_word.pc              = pc;
        fetch_word.instr           = instr;
        fetch_word.predicted_taken = predict_taken;
    end

endmodule

//--- design/register_file.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module register_file (
    input  logic                clk,

    // Read addresses
    input  logic [4:0]          rs1_addr,
    input  logic [4:0]          rs2_addr,

    // Write port
    input  logic [4:0]          wr_addr,
    input  logic                wr_en,
    input  logic [`RV_XLEN-1:0] wr_data,

    output logic [`RV_XLEN-1:0] rs1_data,
    output logic [`RV_XLEN-1:0] rs2_data,
    output logic [`RV_XLEN-1:0] rega0
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    // x0 never takes a write
    always_ff @(posedge clk) begin
        if (wr_en && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    ////////////////////////////////////////
    // Combinational reads
    ////////////////////////////////////////

    // x0 is forced to zero on the read side as well
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

    // a0 for observation
    assign rega0 = regs[10];

endmodule

//--- design/rv_core_top.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_core_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   run,

    // Program load
    input  logic                   imem_we,
    input  logic [`RV_IMEM_AW-1:0] imem_addr,
    input  logic [`RV_XLEN-1:0]    imem_data,

    // Retire trace and status
    output logic                   retire_valid,
    output logic [`RV_XLEN-1:0]    retire_pc,
    output logic [4:0]             retire_rd,
    output logic [`RV_XLEN-1:0]    retire_data,
    output logic                   halted,
    output logic [`RV_XLEN-1:0]    rega0
);

    import rv_pkg::*;

    // Fetch to buffer
    logic                fetch_valid;
    fetch_word_t         fetch_word;

    // Buffer to execute
    logic                buf_valid;
    fetch_word_t         buf_word;

    // Redirect doubles as the buffer flush
    logic                redirect;
    logic [`RV_XLEN-1:0] redirect_pc;

    // Register file traffic
    logic [4:0]          rs1_addr;
    logic [4:0]          rs2_addr;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic                wr_en;
    logic [4:0]          wr_addr;
    logic [`RV_XLEN-1:0] wr_data;

    ////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////

    fetch_stage u_fetch_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_valid (fetch_valid),
        .fetch_word  (fetch_word)
    );

    stage_buffer #(
        .payload_t (fetch_word_t)
    ) u_stage_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (redirect),
        .in_valid    (fetch_valid),
        .in_payload  (fetch_word),
        .out_valid   (buf_valid),
        .out_payload (buf_word)
    );

    ////////////////////////////////////////
    // Execute
    ////////////////////////////////////////

    execute_stage u_execute_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (buf_valid),
        .in_word      (buf_word),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .halted       (halted)
    );

    register_file u_register_file (
        .clk      (clk),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wr_addr  (wr_addr),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rega0    (rega0)
    );

endmodule

//--- design/rv_pkg.sv
`include "rv_params.svh"

package rv_pkg;

    ////////////////////////////////////////
    // Major opcodes of the supported subset
    ////////////////////////////////////////

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_t;

    // ALU functions
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_t;

    // Payload handed from fetch to execute
    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [31:0]         instr;
        logic                predicted_taken;
    } fetch_word_t;

    ////////////////////////////////////////
    // Immediate extraction
    ////////////////////////////////////////

    // I-type, sign extended
    function automatic logic [`RV_XLEN-1:0] get_imm_i(input logic [31:0] instr);
        return {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
    endfunction

    // B-type, bit 0 always zero
    function automatic logic [`RV_XLEN-1:0] get_imm_b(input logic [31:0] instr);
        return {{(`RV_XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    endfunction

    // J-type, bit 0 always zero
    function automatic logic [`RV_XLEN-1:0] get_imm_j(input logic [31:0] instr);
        return {{(`RV_XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    endfunction

endpackage

//--- design/stage_buffer.sv
`timescale 1ns/1ps

module stage_buffer #(
    parameter type payload_t = rv_pkg::fetch_word_t
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,

    // Upstream side
    input  logic     in_valid,
    input  payload_t in_payload,

    // Downstream side
    output logic     out_valid,
    output payload_t out_payload
);

    ////////////////////////////////////////
    // Valid bit
    ////////////////////////////////////////

    // Flush drops whatever is being captured on this edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    ////////////////////////////////////////
    // Payload
    ////////////////////////////////////////

    // Captured every cycle, meaningful only with out_valid
    always_ff @(posedge clk) begin
        out_payload <= in_payload;
    end

endmodule

//--- include/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Data path and address width
`define RV_XLEN 32

// Instruction memory size in 32-bit words
`define RV_IMEM_DEPTH 64

// Word address width into the instruction memory
`define RV_IMEM_AW 6

// Architectural integer registers
`define RV_REG_COUNT 32

`endif

//--- vlog.f
+incdir+include
design/rv_pkg.sv
design/fetch_stage.sv
design/stage_buffer.sv
design/register_file.sv
design/execute_stage.sv
design/rv_core_top.sv
bench/rv_core_tb.sv
